/* src/simproc_pkg.sv */
package simproc_pkg;

    typedef logic [7:0] word_t;
    typedef logic [7:0] addr_t;
    typedef logic [1:0] reg_idx_t;

    // Opcode lives in IR bits 3:0
    typedef enum logic [3:0] {
        OP_LOAD  = 4'b0000,
        OP_JUMP  = 4'b0001,
        OP_STORE = 4'b0010,
        OP_SHIFT = 4'b0011,
        OP_ADD   = 4'b0100,
        OP_BPZ   = 4'b0101,
        OP_SUB   = 4'b0110,
        OP_ORI   = 4'b0111,
        OP_NAND  = 4'b1000,
        OP_BNZ   = 4'b1001,
        OP_BZ    = 4'b1010
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SUB  = 3'b001,
        ALU_OR   = 3'b010,
        ALU_NAND = 3'b011,
        ALU_SHL  = 3'b100,
        ALU_SHR  = 3'b101
    } alu_op_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXEC,
        WRITE,
        ORI_WB
    } cpu_state_t;

    typedef enum logic {
        WSEL_ALU = 1'b0,
        WSEL_MEM = 1'b1
    } wsel_t;

    localparam int       NUM_REGS     = 4;
    localparam int       MEM_DEPTH    = 256;
    localparam reg_idx_t ORI_REG      = 2'd0;

    // SHIFT and ORI decode on the low three bits only
    localparam logic [2:0] SHIFT_SUFFIX = 3'b011;
    localparam logic [2:0] ORI_SUFFIX   = 3'b111;

endpackage

/* src/host_pkg.sv */
package host_pkg;

    // Bit 8 clear selects memory, set selects registers
    typedef logic [8:0] host_addr_t;

    localparam host_addr_t ADDR_CTRL = 9'h100;
    localparam host_addr_t ADDR_PC   = 9'h101;

    // CTRL register layout
    localparam int CTRL_RUN_BIT    = 0;
    localparam int CTRL_STEP_BIT   = 1;
    localparam int CTRL_HALTED_BIT = 7;

endpackage

/* src/cpu_mem_if.sv */
`timescale 1ns/1ps

interface cpu_mem_if
    import simproc_pkg::*;
();

    addr_t addr;
    word_t wdata;
    logic  we;
    word_t rdata;

    modport cpu (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport mem (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

/* src/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control
    import simproc_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    run,
    input  logic    pc_load,
    input  word_t   ir,
    input  logic    n_flag,
    input  logic    z_flag,

    output logic    halted,
    output logic    pc_inc,
    output logic    pc_branch,
    output logic    pc_host_load,
    output logic    ir_load,
    output logic    ab_load,
    output logic    a_from_ori_reg,
    output logic    mdr_load,
    output logic    alu_load,
    output logic    flag_load,
    output logic    rf_write,
    output logic    mem_we,
    output logic    addr_from_pc,
    output alu_op_t alu_op,
    output logic [1:0] alu_b_sel,
    output wsel_t   wsel,
    output logic    rf_wsel_ori
);

    cpu_state_t state;
    cpu_state_t next_state;
    cpu_state_t retire_state;
    opcode_t    opcode;
    logic       is_shift;
    logic       is_ori;
    logic       branch_taken;

    assign opcode   = opcode_t'(ir[3:0]);
    assign is_shift = (ir[2:0] == SHIFT_SUFFIX);
    assign is_ori   = (ir[2:0] == ORI_SUFFIX);

    assign halted       = (state == IDLE);
    // Host may only move the PC while stopped
    assign pc_host_load = halted && pc_load;

    // Step pulse or run latch keeps fetching
    assign retire_state = run ? FETCH : IDLE;

    always_comb begin
        case (opcode)
            OP_BNZ:  branch_taken = !z_flag;
            OP_BPZ:  branch_taken = !n_flag;
            OP_BZ:   branch_taken = z_flag;
            OP_JUMP: branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        next_state     = state;
        pc_inc         = 1'b0;
        pc_branch      = 1'b0;
        ir_load        = 1'b0;
        ab_load        = 1'b0;
        a_from_ori_reg = 1'b0;
        mdr_load       = 1'b0;
        alu_load       = 1'b0;
        flag_load      = 1'b0;
        rf_write       = 1'b0;
        mem_we         = 1'b0;
        addr_from_pc   = 1'b0;
        alu_op         = ALU_ADD;
        alu_b_sel      = 2'd0;
        wsel           = WSEL_ALU;
        rf_wsel_ori    = 1'b0;

        case (state)
            IDLE: begin
                if (run) begin
                    next_state = FETCH;
                end
            end

            FETCH: begin
                addr_from_pc = 1'b1;
                ir_load      = 1'b1;
                pc_inc       = 1'b1;
                next_state   = DECODE;
            end

            DECODE: begin
                ab_load    = 1'b1;
                next_state = EXEC;
            end

            EXEC: begin
                if (is_shift) begin
                    // IR bit 5 picks the direction
                    alu_op     = ir[5] ? ALU_SHL : ALU_SHR;
                    alu_b_sel  = 2'd1;
                    alu_load   = 1'b1;
                    flag_load  = 1'b1;
                    next_state = WRITE;
                end else if (is_ori) begin
                    ab_load        = 1'b1;
                    a_from_ori_reg = 1'b1;
                    next_state     = WRITE;
                end else begin
                    case (opcode)
                        OP_ADD, OP_SUB, OP_NAND: begin
                            alu_op = (opcode == OP_SUB)  ? ALU_SUB :
                                     (opcode == OP_NAND) ? ALU_NAND : ALU_ADD;
                            alu_load   = 1'b1;
                            flag_load  = 1'b1;
                            next_state = WRITE;
                        end
                        OP_LOAD: begin
                            mdr_load   = 1'b1;
                            next_state = WRITE;
                        end
                        OP_STORE: begin
                            mem_we     = 1'b1;
                            next_state = retire_state;
                        end
                        OP_BNZ, OP_BPZ, OP_BZ, OP_JUMP: begin
                            pc_branch  = branch_taken;
                            next_state = retire_state;
                        end
                        // Undefined opcodes fall through as no-ops
                        default: next_state = retire_state;
                    endcase
                end
            end

            WRITE: begin
                if (is_ori) begin
                    alu_op     = ALU_OR;
                    alu_b_sel  = 2'd2;
                    alu_load   = 1'b1;
                    flag_load  = 1'b1;
                    next_state = ORI_WB;
                end else begin
                    rf_write   = 1'b1;
                    wsel       = (opcode == OP_LOAD) ? WSEL_MEM : WSEL_ALU;
                    next_state = retire_state;
                end
            end

            ORI_WB: begin
                rf_write    = 1'b1;
                rf_wsel_ori = 1'b1;
                next_state  = retire_state;
            end

            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {IDLE, FETCH, DECODE, EXEC, WRITE, ORI_WB})
        else $error("cpu_control left the legal state set");

endmodule

/* src/program_counter.sv */
`timescale 1ns/1ps

module program_counter
    import simproc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pc_inc,
    input  logic       pc_branch,
    input  logic       pc_host_load,
    input  logic [3:0] offset,
    input  addr_t      host_val,
    output addr_t      pc
);

    addr_t offset_ext;

    // Branch offset is relative to the already incremented PC
    assign offset_ext = {{4{offset[3]}}, offset};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_host_load) begin
            pc <= host_val;
        end else if (pc_inc) begin
            pc <= pc + 8'd1;
        end else if (pc_branch) begin
            pc <= pc + offset_ext;
        end
    end

    a_single_req: assert property (@(posedge clk) disable iff (rst)
        $onehot0({pc_inc, pc_branch, pc_host_load}))
        else $error("conflicting PC update requests");

endmodule

/* src/datapath.sv */
`timescale 1ns/1ps

module datapath
    import simproc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ir_load,
    input  logic       ab_load,
    input  logic       a_from_ori_reg,
    input  logic       mdr_load,
    input  logic       alu_load,
    input  logic       flag_load,
    input  logic       rf_write,
    input  logic       mem_we,
    input  logic       addr_from_pc,
    input  alu_op_t    alu_op,
    input  logic [1:0] alu_b_sel,
    input  wsel_t      wsel,
    input  logic       rf_wsel_ori,
    input  addr_t      pc,

    output word_t      ir,
    output logic       n_flag,
    output logic       z_flag,

    cpu_mem_if.cpu     mem
);

    word_t    rf [NUM_REGS];
    word_t    mdr;
    word_t    a_reg;
    word_t    b_reg;
    word_t    alu_reg;
    word_t    alu_b;
    word_t    alu_y;
    reg_idx_t ra_idx;
    reg_idx_t rb_idx;
    reg_idx_t rw_idx;
    word_t    rf_wdata;

    // rA in IR bits 7:6, rB in bits 5:4
    assign ra_idx   = a_from_ori_reg ? ORI_REG : ir[7:6];
    assign rb_idx   = ir[5:4];
    assign rw_idx   = rf_wsel_ori ? ORI_REG : ir[7:6];
    assign rf_wdata = (wsel == WSEL_MEM) ? mdr : alu_reg;

    always_comb begin
        case (alu_b_sel)
            2'd1:    alu_b = {6'b0, ir[4:3]};
            2'd2:    alu_b = {3'b0, ir[7:3]};
            default: alu_b = b_reg;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_y = a_reg + alu_b;
            ALU_SUB:  alu_y = a_reg - alu_b;
            ALU_OR:   alu_y = a_reg | alu_b;
            ALU_NAND: alu_y = ~(a_reg & alu_b);
            ALU_SHL:  alu_y = a_reg << alu_b[1:0];
            ALU_SHR:  alu_y = a_reg >> alu_b[1:0];
            default:  alu_y = '0;
        endcase
    end

    assign mem.addr  = addr_from_pc ? pc : b_reg;
    assign mem.wdata = a_reg;
    assign mem.we    = mem_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            ir     <= '0;
            n_flag <= 1'b0;
            z_flag <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else begin
            if (ir_load) begin
                ir <= mem.rdata;
            end
            if (flag_load) begin
                n_flag <= alu_y[7];
                z_flag <= (alu_y == '0);
            end
            if (rf_write) begin
                rf[rw_idx] <= rf_wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mdr_load) begin
            mdr <= mem.rdata;
        end
        if (ab_load) begin
            a_reg <= rf[ra_idx];
            b_reg <= rf[rb_idx];
        end
        if (alu_load) begin
            alu_reg <= alu_y;
        end
    end

endmodule

/* src/dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram
    import simproc_pkg::*;
(
    input  logic   clk,
    input  addr_t  host_addr,
    input  word_t  host_wdata,
    input  logic   host_we,
    output word_t  host_rdata,

    cpu_mem_if.mem mem
);

    word_t ram [MEM_DEPTH];
    logic  collide;

    // Processor write wins when both ports hit one address
    assign collide = mem.we && (mem.addr == host_addr);

    always_ff @(posedge clk) begin
        if (mem.we) begin
            ram[mem.addr] <= mem.wdata;
        end
        if (host_we && !collide) begin
            ram[host_addr] <= host_wdata;
        end
    end

    assign mem.rdata  = ram[mem.addr];
    assign host_rdata = ram[host_addr];

endmodule

/* src/host_port.sv */
`timescale 1ns/1ps

module host_port
    import simproc_pkg::*, host_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  host_addr_t wb_adr,
    input  word_t      wb_dat_w,
    input  logic       halted,
    input  addr_t      pc,
    input  word_t      ram_rdata,

    output word_t      wb_dat_r,
    output logic       wb_ack,
    output addr_t      ram_addr,
    output word_t      ram_wdata,
    output logic       ram_we,
    output logic       run,
    output logic       pc_load,
    output addr_t      pc_load_val
);

    logic  access;
    logic  is_mem;
    logic  run_latch;
    logic  step_pulse;
    word_t ctrl_rd;
    word_t rd_val;

    // Strobe ignored during the ack cycle
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign is_mem = !wb_adr[8];

    assign ram_addr    = wb_adr[7:0];
    assign ram_wdata   = wb_dat_w;
    assign ram_we      = access && wb_we && is_mem;
    assign pc_load     = access && wb_we && (wb_adr == ADDR_PC);
    assign pc_load_val = wb_dat_w;
    assign run         = run_latch || step_pulse;

    always_comb begin
        ctrl_rd                  = '0;
        ctrl_rd[CTRL_RUN_BIT]    = run_latch;
        ctrl_rd[CTRL_HALTED_BIT] = halted;
        if (is_mem) begin
            rd_val = ram_rdata;
        end else if (wb_adr == ADDR_CTRL) begin
            rd_val = ctrl_rd;
        end else if (wb_adr == ADDR_PC) begin
            rd_val = pc;
        end else begin
            rd_val = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            run_latch  <= 1'b0;
            step_pulse <= 1'b0;
        end else begin
            wb_ack     <= access;
            step_pulse <= 1'b0;
            if (access && wb_we && (wb_adr == ADDR_CTRL)) begin
                run_latch  <= wb_dat_w[CTRL_RUN_BIT];
                step_pulse <= wb_dat_w[CTRL_STEP_BIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !wb_we) begin
            wb_dat_r <= rd_val;
        end
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack high outside an active bus cycle");

endmodule

/* src/simproc_top.sv */
`timescale 1ns/1ps

module simproc_top
    import simproc_pkg::*, host_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  host_addr_t wb_adr,
    input  word_t      wb_dat_w,
    output word_t      wb_dat_r,
    output logic       wb_ack,
    output logic       halted
);

    addr_t      pc;
    addr_t      ram_addr;
    word_t      ram_wdata;
    word_t      ram_rdata;
    logic       ram_we;
    logic       run;
    logic       pc_load;
    addr_t      pc_load_val;
    word_t      ir;
    logic       n_flag;
    logic       z_flag;
    logic       pc_inc;
    logic       pc_branch;
    logic       pc_host_load;
    logic       ir_load;
    logic       ab_load;
    logic       a_from_ori_reg;
    logic       mdr_load;
    logic       alu_load;
    logic       flag_load;
    logic       rf_write;
    logic       mem_we;
    logic       addr_from_pc;
    alu_op_t    alu_op;
    logic [1:0] alu_b_sel;
    wsel_t      wsel;
    logic       rf_wsel_ori;

    cpu_mem_if u_mem_if ();

    host_port u_host_port (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .halted      (halted),
        .pc          (pc),
        .ram_rdata   (ram_rdata),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_we      (ram_we),
        .run         (run),
        .pc_load     (pc_load),
        .pc_load_val (pc_load_val)
    );

    cpu_control u_control (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .pc_load        (pc_load),
        .ir             (ir),
        .n_flag         (n_flag),
        .z_flag         (z_flag),
        .halted         (halted),
        .pc_inc         (pc_inc),
        .pc_branch      (pc_branch),
        .pc_host_load   (pc_host_load),
        .ir_load        (ir_load),
        .ab_load        (ab_load),
        .a_from_ori_reg (a_from_ori_reg),
        .mdr_load       (mdr_load),
        .alu_load       (alu_load),
        .flag_load      (flag_load),
        .rf_write       (rf_write),
        .mem_we         (mem_we),
        .addr_from_pc   (addr_from_pc),
        .alu_op         (alu_op),
        .alu_b_sel      (alu_b_sel),
        .wsel           (wsel),
        .rf_wsel_ori    (rf_wsel_ori)
    );

    // Branch offset from IR bits 7:4
    program_counter u_pc (
        .clk          (clk),
        .rst          (rst),
        .pc_inc       (pc_inc),
        .pc_branch    (pc_branch),
        .pc_host_load (pc_host_load),
        .offset       (ir[7:4]),
        .host_val     (pc_load_val),
        .pc           (pc)
    );

    datapath u_datapath (
        .clk            (clk),
        .rst            (rst),
        .ir_load        (ir_load),
        .ab_load        (ab_load),
        .a_from_ori_reg (a_from_ori_reg),
        .mdr_load       (mdr_load),
        .alu_load       (alu_load),
        .flag_load      (flag_load),
        .rf_write       (rf_write),
        .mem_we         (mem_we),
        .addr_from_pc   (addr_from_pc),
        .alu_op         (alu_op),
        .alu_b_sel      (alu_b_sel),
        .wsel           (wsel),
        .rf_wsel_ori    (rf_wsel_ori),
        .pc             (pc),
        .ir             (ir),
        .n_flag         (n_flag),
        .z_flag         (z_flag),
        .mem            (u_mem_if.cpu)
    );

    dual_port_ram u_ram (
        .clk        (clk),
        .host_addr  (ram_addr),
        .host_wdata (ram_wdata),
        .host_we    (ram_we),
        .host_rdata (ram_rdata),
        .mem        (u_mem_if.mem)
    );

endmodule

/* tests/tb_simproc.sv */
`timescale 1ns/1ps

module tb_simproc
    import simproc_pkg::*, host_pkg::*;
();

    logic       clk;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    host_addr_t wb_adr;
    word_t      wb_dat_w;
    word_t      wb_dat_r;
    logic       wb_ack;
    logic       halted;

    int    errors;
    int    cur_errors;
    int    test_count;
    int    failed_tests;
    logic  aborted;
    logic  halted_at_ack;
    string cur_test;

    simproc_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
            cur_errors++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s (test %s)", msg, cur_test);
        errors++;
        cur_errors++;
    endtask

    // One bus cycle, driven at posedge and sampled at negedge
    task automatic wb_access(input logic we, input host_addr_t adr, input word_t wdat,
                             output word_t rdat);
        int cycles;
        cycles   = 0;
        rdat     = '0;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_ack && cycles < 20);
        if (!wb_ack) begin
            note_failure($sformatf("no ack from address %03h", adr));
            aborted = 1'b1;
        end else begin
            rdat          = wb_dat_r;
            halted_at_ack = halted;
            check({cur_test, " ack latency"}, 2, cycles);
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_halted();
        word_t ctrl;
        int    polls;
        ctrl  = '0;
        polls = 0;
        while (!ctrl[CTRL_HALTED_BIT] && polls < 100 && !aborted) begin
            wb_access(1'b0, ADDR_CTRL, '0, ctrl);
            polls++;
        end
        if (!ctrl[CTRL_HALTED_BIT] && !aborted) begin
            note_failure("processor did not halt in time");
            aborted = 1'b1;
        end
    endtask

    // Memory markers are stable once written, unlike the looping PC
    task automatic poll_until(input host_addr_t adr, input word_t want);
        word_t got;
        int    polls;
        got   = ~want;
        polls = 0;
        while (got !== want && polls < 200 && !aborted) begin
            wb_access(1'b0, adr, '0, got);
            polls++;
        end
        if (got !== want && !aborted) begin
            note_failure($sformatf("address %03h never reached %02h", adr, want));
            aborted = 1'b1;
        end
    endtask

    task automatic finish_test();
        if (cur_test != "") begin
            test_count++;
            if (cur_errors == 0) begin
                $display("test %s: ok", cur_test);
            end else begin
                failed_tests++;
                $display("test %s: %0d error(s)", cur_test, cur_errors);
            end
        end
    endtask

    initial begin
        int    fd;
        int    nfields;
        int    adr_val;
        int    dat_val;
        string line;
        string name;
        string op;
        word_t rdat;

        rst          <= 1'b1;
        wb_cyc       <= 1'b0;
        wb_stb       <= 1'b0;
        wb_we        <= 1'b0;
        wb_adr       <= '0;
        wb_dat_w     <= '0;
        errors       = 0;
        cur_errors   = 0;
        test_count   = 0;
        failed_tests = 0;
        aborted      = 1'b0;
        halted_at_ack = 1'b0;
        cur_test     = "";

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        fd = $fopen("tests/simproc_golden.txt", "r");
        if (fd == 0) begin
            note_failure("cannot open tests/simproc_golden.txt");
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                nfields = $sscanf(line, "%s %s %h %h", name, op, adr_val, dat_val);
                if (line[0] != "#" && nfields == 4) begin
                    if (name != cur_test) begin
                        finish_test();
                        cur_test   = name;
                        cur_errors = 0;
                    end
                    if (op == "W") begin
                        wb_access(1'b1, host_addr_t'(adr_val), word_t'(dat_val), rdat);
                    end else if (op == "R") begin
                        wb_access(1'b0, host_addr_t'(adr_val), '0, rdat);
                        check($sformatf("%s @%03h", name, adr_val), dat_val, int'(rdat));
                        // Halted pin follows CTRL bit 7
                        if (host_addr_t'(adr_val) == ADDR_CTRL) begin
                            check($sformatf("%s halted output", name),
                                  int'(dat_val[CTRL_HALTED_BIT]), int'(halted_at_ack));
                        end
                    end else if (op == "H") begin
                        wait_halted();
                    end else if (op == "P") begin
                        poll_until(host_addr_t'(adr_val), word_t'(dat_val));
                    end else begin
                        note_failure($sformatf("unknown operation %s in golden file", op));
                    end
                end
            end
            finish_test();
            $fclose(fd);
        end

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, errors);
        if (errors == 0 && test_count > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tests/simproc_golden.txt */
# columns: test name, op, host address (hex), value (hex)
# op: W write, R read and compare, H wait until halted, P read until value
mem_rw W 080 3c
mem_rw W 0a5 5a
mem_rw W 0c3 e1
mem_rw R 080 3c
mem_rw R 0a5 5a
mem_rw R 0c3 e1
reset_state R 100 80
reset_state R 101 00
reset_state W 101 40
reset_state R 101 40
step W 005 aa
step W 010 2f
step W 011 02
step W 101 10
step W 100 02
step H 100 00
step R 101 11
step R 100 80
step R 005 aa
step W 100 02
step H 100 00
step R 101 12
step R 100 80
step R 005 05
alu_prog W 020 c7
alu_prog W 021 44
alu_prog W 022 7b
alu_prog W 023 84
alu_prog W 024 9b
alu_prog W 025 8b
alu_prog W 026 d4
alu_prog W 027 32
alu_prog W 028 e4
alu_prog W 029 72
alu_prog W 02a e4
alu_prog W 02b 66
alu_prog W 02c 72
alu_prog W 02d 48
alu_prog W 02e e4
alu_prog W 02f 72
alu_prog W 030 e4
alu_prog W 031 30
alu_prog W 032 26
alu_prog W 033 e4
alu_prog W 034 32
alu_prog W 035 e4
alu_prog W 036 b2
alu_prog W 037 f1
alu_prog W 0ec 3c
alu_prog W 0ee 00
alu_prog W 101 20
alu_prog W 100 01
alu_prog P 0ee 01
alu_prog W 100 00
alu_prog H 100 00
alu_prog R 0e8 1d
alu_prog R 0e9 e8
alu_prog R 0ea e7
alu_prog R 0eb fa
alu_prog R 0ec 3c
alu_prog R 0ed 3b
alu_prog R 0ee 01
alu_prog R 101 37
branch_prog W 040 56
branch_prog W 041 1a
branch_prog W 042 64
branch_prog W 043 e4
branch_prog W 044 72
branch_prog W 045 64
branch_prog W 046 19
branch_prog W 047 64
branch_prog W 048 1a
branch_prog W 049 64
branch_prog W 04a 15
branch_prog W 04b 64
branch_prog W 04c 06
branch_prog W 04d 19
branch_prog W 04e 64
branch_prog W 04f 08
branch_prog W 050 15
branch_prog W 051 64
branch_prog W 052 11
branch_prog W 053 64
branch_prog W 054 e4
branch_prog W 055 72
branch_prog W 056 f1
branch_prog W 0ef aa
branch_prog W 0f0 00
branch_prog W 101 40
branch_prog W 100 01
branch_prog P 0f0 04
branch_prog W 100 00
branch_prog H 100 00
branch_prog R 0ef 00
branch_prog R 0f0 04
branch_prog R 101 56
branch_prog R 100 80

/* sources.f */
src/simproc_pkg.sv
src/host_pkg.sv
src/cpu_mem_if.sv
src/cpu_control.sv
src/program_counter.sv
src/datapath.sv
src/dual_port_ram.sv
src/host_port.sv
src/simproc_top.sv
tests/tb_simproc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_simproc
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sources.f
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(BUILD_DIR)
